/* common/cpu_pkg.sv */
//==================================================
// Shared widths, reset constants, encodings and
// stage structs of the RV32I core
// Only word-sized loads and stores exist
// The valid bit of each struct marks a live item
//==================================================
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32;

	// First fetch address and initial x2
	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;
	localparam logic [XLEN-1:0] STACK_POINTER = 32'h0000_0400;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		OP_LUI = 7'b0110111,
		OP_IMM = 7'b0010011,
		OP_REG = 7'b0110011,
		OP_LOAD = 7'b0000011,
		OP_STORE = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	//==================================================
	// Stage structs

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instruction;
	} fetch_data_t;

	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [XLEN-1:0] imm;
		alu_op_e alu_op;
		logic use_imm;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic branch_ne;
		logic is_jal;
		logic writes_rd;
		logic fault;
	} decode_data_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic writes_rd;
		logic is_load;
		logic is_store;
		// ALU result, memory address or link address
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
	} execute_data_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic writes_rd;
		logic [XLEN-1:0] value;
	} memory_data_t;

endpackage

`default_nettype wire

/* src/cpu_fetch.sv */
//==================================================
// Instruction fetch with one outstanding request
// A word arriving while the output is held or a
// redirect is pending is dropped and fetched again
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_jump,
	input logic [cpu_pkg::XLEN-1:0] i_jump_pc,
	input logic i_busy,
	input logic i_halt,
	output logic o_ibus_request,
	input logic i_ibus_ready,
	output logic [cpu_pkg::XLEN-1:0] o_ibus_address,
	input logic [cpu_pkg::XLEN-1:0] i_ibus_rdata,
	output cpu_pkg::fetch_data_t o_data
);

	logic [cpu_pkg::XLEN-1:0] pc;
	logic [cpu_pkg::XLEN-1:0] pc_next;
	logic discard;
	logic transfer;
	logic capture;
	logic issue;

	assign transfer = o_ibus_request && i_ibus_ready;
	// Keep the word only if the output register can take it
	assign capture = transfer && !discard && !i_jump && (!o_data.valid || !i_busy);
	assign issue = !i_halt && !(i_busy && (o_data.valid || capture));
	assign pc_next = i_jump ? i_jump_pc : (capture ? o_ibus_address + 32'd4 : pc);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc <= cpu_pkg::RESET_VECTOR;
			discard <= 1'b0;
			o_ibus_request <= 1'b0;
			o_ibus_address <= cpu_pkg::RESET_VECTOR;
			o_data <= '0;
		end else begin
			pc <= pc_next;
			// Redirect during a pending transfer drops the returned word
			discard <= o_ibus_request && !i_ibus_ready && (discard || i_jump);
			if (!o_ibus_request || i_ibus_ready) begin
				o_ibus_request <= issue;
				o_ibus_address <= pc_next;
			end
			if (i_jump) begin
				o_data.valid <= 1'b0;
			end else if (!o_data.valid || !i_busy) begin
				o_data.valid <= capture;
				o_data.pc <= o_ibus_address;
				o_data.instruction <= i_ibus_rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* src/cpu_decode.sv */
//==================================================
// Instruction decode, one registered stage
// Unused source fields are zeroed so they never
// cause a forward or a load-use stall
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_flush,
	input logic i_busy,
	input cpu_pkg::fetch_data_t i_data,
	output cpu_pkg::decode_data_t o_data
);

	cpu_pkg::decode_data_t next;
	cpu_pkg::opcode_e opcode;
	cpu_pkg::alu_op_e alu_f3;
	logic f3_ok;
	logic [cpu_pkg::XLEN-1:0] instr;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [cpu_pkg::XLEN-1:0] imm_i;
	logic [cpu_pkg::XLEN-1:0] imm_s;
	logic [cpu_pkg::XLEN-1:0] imm_b;
	logic [cpu_pkg::XLEN-1:0] imm_j;

	assign instr = i_data.instruction;
	assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// Sign-extended immediates
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// funct3 mapping shared by register and immediate forms
	always_comb begin
		f3_ok = 1'b1;
		case (funct3)
			3'b000: alu_f3 = cpu_pkg::ALU_ADD;
			3'b010: alu_f3 = cpu_pkg::ALU_SLT;
			3'b100: alu_f3 = cpu_pkg::ALU_XOR;
			3'b110: alu_f3 = cpu_pkg::ALU_OR;
			3'b111: alu_f3 = cpu_pkg::ALU_AND;
			default: begin
				alu_f3 = cpu_pkg::ALU_ADD;
				f3_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		next = '0;
		next.valid = i_data.valid;
		next.pc = i_data.pc;
		next.rd = instr[11:7];
		next.rs1 = instr[19:15];
		next.alu_op = cpu_pkg::ALU_ADD;
		case (opcode)
			cpu_pkg::OP_LUI: begin
				next.rs1 = 5'd0;
				next.imm = {instr[31:12], 12'b0};
				next.alu_op = cpu_pkg::ALU_PASS_B;
				next.use_imm = 1'b1;
				next.writes_rd = 1'b1;
			end
			cpu_pkg::OP_IMM: begin
				next.imm = imm_i;
				next.alu_op = alu_f3;
				next.use_imm = 1'b1;
				next.writes_rd = 1'b1;
				next.fault = !f3_ok;
			end
			cpu_pkg::OP_REG: begin
				next.rs2 = instr[24:20];
				next.writes_rd = 1'b1;
				if (funct7 == 7'b0100000 && funct3 == 3'b000)
					next.alu_op = cpu_pkg::ALU_SUB;
				else
					next.alu_op = alu_f3;
				next.fault = !((funct7 == 7'b0100000 && funct3 == 3'b000) ||
					(funct7 == 7'b0000000 && f3_ok));
			end
			cpu_pkg::OP_LOAD: begin
				next.imm = imm_i;
				next.use_imm = 1'b1;
				next.is_load = 1'b1;
				next.writes_rd = 1'b1;
				next.fault = funct3 != 3'b010;
			end
			cpu_pkg::OP_STORE: begin
				next.rs2 = instr[24:20];
				next.imm = imm_s;
				next.use_imm = 1'b1;
				next.is_store = 1'b1;
				next.fault = funct3 != 3'b010;
			end
			cpu_pkg::OP_BRANCH: begin
				next.rs2 = instr[24:20];
				next.imm = imm_b;
				next.is_branch = 1'b1;
				next.branch_ne = funct3[0];
				next.fault = funct3[2:1] != 2'b00;
			end
			cpu_pkg::OP_JAL: begin
				next.rs1 = 5'd0;
				next.imm = imm_j;
				next.is_jal = 1'b1;
				next.writes_rd = 1'b1;
			end
			default: next.fault = 1'b1;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_data <= '0;
		else if (i_flush)
			o_data.valid <= 1'b0;
		else if (!i_busy)
			o_data <= next;
	end

endmodule

`default_nettype wire

/* src/cpu_registers.sv */
//==================================================
// Register file, two read ports and one write port
// x0 reads zero, x2 starts at the stack pointer
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_registers (
	input logic i_clock,
	input logic i_arst_n,
	input logic [4:0] i_rs1_index,
	input logic [4:0] i_rs2_index,
	output logic [cpu_pkg::XLEN-1:0] o_rs1,
	output logic [cpu_pkg::XLEN-1:0] o_rs2,
	input cpu_pkg::memory_data_t i_memory_data
);

	logic [cpu_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= (i == 2) ? cpu_pkg::STACK_POINTER : '0;
		end else if (i_memory_data.valid && i_memory_data.writes_rd &&
			i_memory_data.rd != 5'd0) begin
			regs[i_memory_data.rd] <= i_memory_data.value;
		end
	end

	assign o_rs1 = (i_rs1_index == 5'd0) ? '0 : regs[i_rs1_index];
	assign o_rs2 = (i_rs2_index == 5'd0) ? '0 : regs[i_rs2_index];

endmodule

`default_nettype wire

/* src/cpu_forward.sv */
//==================================================
// Operand forwarding for the instruction in execute
// Loads in execute are not forwarded, the load-use
// stall covers them
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_forward (
	input cpu_pkg::decode_data_t i_decode_data,
	input cpu_pkg::execute_data_t i_execute_data,
	input cpu_pkg::memory_data_t i_memory_data,
	input logic [cpu_pkg::XLEN-1:0] i_rs1,
	input logic [cpu_pkg::XLEN-1:0] i_rs2,
	output logic [cpu_pkg::XLEN-1:0] o_rs1,
	output logic [cpu_pkg::XLEN-1:0] o_rs2
);

	// Newest producer wins
	function automatic logic [cpu_pkg::XLEN-1:0] pick(
		input logic [4:0] rs,
		input logic [cpu_pkg::XLEN-1:0] rf_value,
		input cpu_pkg::execute_data_t ex,
		input cpu_pkg::memory_data_t mem
	);
		if (rs != 5'd0 && ex.valid && ex.writes_rd && !ex.is_load && ex.rd == rs)
			return ex.result;
		if (rs != 5'd0 && mem.valid && mem.writes_rd && mem.rd == rs)
			return mem.value;
		return rf_value;
	endfunction

	assign o_rs1 = pick(i_decode_data.rs1, i_rs1, i_execute_data, i_memory_data);
	assign o_rs2 = pick(i_decode_data.rs2, i_rs2, i_execute_data, i_memory_data);

endmodule

`default_nettype wire

/* src/cpu_execute.sv */
//==================================================
// Execute stage: ALU, branch and jump resolution
// Taken branches and JAL flush fetch and decode
// After a fault no new item is taken
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
	input logic i_clock,
	input logic i_arst_n,
	input cpu_pkg::decode_data_t i_data,
	input logic [cpu_pkg::XLEN-1:0] i_rs1,
	input logic [cpu_pkg::XLEN-1:0] i_rs2,
	input logic i_memory_busy,
	output logic o_busy,
	output logic o_jump,
	output logic [cpu_pkg::XLEN-1:0] o_jump_pc,
	output logic o_fault,
	output cpu_pkg::execute_data_t o_data
);

	logic [cpu_pkg::XLEN-1:0] operand_b;
	logic [cpu_pkg::XLEN-1:0] alu_result;
	logic load_use;
	logic accept;
	logic taken;

	// Source waits one cycle for a load still in our output register
	assign load_use = i_data.valid && o_data.valid && o_data.is_load && o_data.rd != 5'd0 &&
		(o_data.rd == i_data.rs1 || o_data.rd == i_data.rs2);
	assign o_busy = i_memory_busy || load_use || o_fault;
	assign accept = i_data.valid && !i_data.fault && !o_busy;

	assign taken = i_data.is_jal ||
		(i_data.is_branch && ((i_rs1 == i_rs2) != i_data.branch_ne));
	assign o_jump = accept && taken;
	assign o_jump_pc = i_data.pc + i_data.imm;

	assign operand_b = i_data.use_imm ? i_data.imm : i_rs2;

	always_comb begin
		case (i_data.alu_op)
			cpu_pkg::ALU_ADD: alu_result = i_rs1 + operand_b;
			cpu_pkg::ALU_SUB: alu_result = i_rs1 - operand_b;
			cpu_pkg::ALU_AND: alu_result = i_rs1 & operand_b;
			cpu_pkg::ALU_OR: alu_result = i_rs1 | operand_b;
			cpu_pkg::ALU_XOR: alu_result = i_rs1 ^ operand_b;
			cpu_pkg::ALU_SLT: alu_result = {31'b0, $signed(i_rs1) < $signed(operand_b)};
			default: alu_result = operand_b;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_fault <= 1'b0;
			o_data <= '0;
		end else begin
			if (i_data.valid && i_data.fault)
				o_fault <= 1'b1;
			// Output register moves whenever memory can take it, a bubble if nothing accepted
			if (!i_memory_busy) begin
				o_data.valid <= accept;
				o_data.rd <= i_data.rd;
				o_data.writes_rd <= i_data.writes_rd;
				o_data.is_load <= i_data.is_load;
				o_data.is_store <= i_data.is_store;
				o_data.result <= i_data.is_jal ? i_data.pc + 32'd4 : alu_result;
				o_data.store_data <= i_rs2;
			end
		end
	end

endmodule

`default_nettype wire

/* src/cpu_memory.sv */
//==================================================
// Memory and writeback stage
// Bus request is driven straight from the execute
// output register, which holds while we are busy
// Word accesses only
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_memory (
	input logic i_clock,
	input logic i_arst_n,
	input cpu_pkg::execute_data_t i_data,
	output logic o_busy,
	output logic o_dbus_request,
	output logic o_dbus_rw,
	input logic i_dbus_ready,
	output logic [cpu_pkg::XLEN-1:0] o_dbus_address,
	input logic [cpu_pkg::XLEN-1:0] i_dbus_rdata,
	output logic [cpu_pkg::XLEN-1:0] o_dbus_wdata,
	output cpu_pkg::memory_data_t o_data
);

	logic access;

	assign access = i_data.valid && (i_data.is_load || i_data.is_store);

	//==================================================
	// Data bus

	assign o_dbus_request = access;
	assign o_dbus_rw = i_data.is_store;
	assign o_dbus_address = i_data.result;
	assign o_dbus_wdata = i_data.store_data;
	assign o_busy = access && !i_dbus_ready;

	//==================================================
	// Writeback result

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_data <= '0;
		end else begin
			o_data.valid <= i_data.valid && !o_busy;
			o_data.rd <= i_data.rd;
			o_data.writes_rd <= i_data.writes_rd;
			o_data.value <= i_data.is_load ? i_dbus_rdata : i_data.result;
		end
	end

endmodule

`default_nettype wire

/* src/cpu.sv */
//==================================================
// RV32I core top level, four stage pipeline
// Bus request holds until ready, one outstanding
// o_fault is sticky until reset
//==================================================
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input logic i_clock,
	input logic i_arst_n,

	// Instruction bus
	output logic o_ibus_request,
	input logic i_ibus_ready,
	output logic [cpu_pkg::XLEN-1:0] o_ibus_address,
	input logic [cpu_pkg::XLEN-1:0] i_ibus_rdata,

	// Data bus
	output logic o_dbus_request,
	output logic o_dbus_rw,
	input logic i_dbus_ready,
	output logic [cpu_pkg::XLEN-1:0] o_dbus_address,
	input logic [cpu_pkg::XLEN-1:0] i_dbus_rdata,
	output logic [cpu_pkg::XLEN-1:0] o_dbus_wdata,

	output logic o_fault
);

	cpu_pkg::fetch_data_t fetch_data;
	cpu_pkg::decode_data_t decode_data;
	cpu_pkg::execute_data_t execute_data;
	cpu_pkg::memory_data_t memory_data;

	logic [cpu_pkg::XLEN-1:0] rs1;
	logic [cpu_pkg::XLEN-1:0] rs2;
	logic [cpu_pkg::XLEN-1:0] forward_rs1;
	logic [cpu_pkg::XLEN-1:0] forward_rs2;
	logic [cpu_pkg::XLEN-1:0] jump_pc;
	logic jump;
	logic execute_busy;
	logic memory_busy;

	//==================================================
	// Fetch and decode

	cpu_fetch fetch (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_busy(execute_busy),
		.i_halt(o_fault),
		.o_ibus_request(o_ibus_request),
		.i_ibus_ready(i_ibus_ready),
		.o_ibus_address(o_ibus_address),
		.i_ibus_rdata(i_ibus_rdata),
		.o_data(fetch_data)
	);

	cpu_decode decode (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_flush(jump),
		.i_busy(execute_busy),
		.i_data(fetch_data),
		.o_data(decode_data)
	);

	//==================================================
	// Operands

	cpu_registers registers (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_rs1_index(decode_data.rs1),
		.i_rs2_index(decode_data.rs2),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_memory_data(memory_data)
	);

	cpu_forward forward (
		.i_decode_data(decode_data),
		.i_execute_data(execute_data),
		.i_memory_data(memory_data),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rs1(forward_rs1),
		.o_rs2(forward_rs2)
	);

	//==================================================
	// Execute and memory

	cpu_execute execute (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_data(decode_data),
		.i_rs1(forward_rs1),
		.i_rs2(forward_rs2),
		.i_memory_busy(memory_busy),
		.o_busy(execute_busy),
		.o_jump(jump),
		.o_jump_pc(jump_pc),
		.o_fault(o_fault),
		.o_data(execute_data)
	);

	cpu_memory memory (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_data(execute_data),
		.o_busy(memory_busy),
		.o_dbus_request(o_dbus_request),
		.o_dbus_rw(o_dbus_rw),
		.i_dbus_ready(i_dbus_ready),
		.o_dbus_address(o_dbus_address),
		.i_dbus_rdata(i_dbus_rdata),
		.o_dbus_wdata(o_dbus_wdata),
		.o_data(memory_data)
	);

endmodule

`default_nettype wire

/* verification/tb_cpu.sv */
//==================================================
// Testbench for the RV32I core
// Loads verification/program.hex, run from the
// project root
// Both bus slaves answer after 0 to 3 random waits
// Stores are checked in program order, then the
// fault must hold with a quiet data bus
//==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	// 64 instructions, 4 wait cycles each, margin of 4
	localparam int TIMEOUT_CYCLES = 64 * 4 * 4;
	localparam int QUIET_CYCLES = 20;

	logic clock = 1'b0;
	logic arst_n;
	logic ibus_request;
	logic ibus_ready;
	logic [31:0] ibus_address;
	logic [31:0] ibus_rdata;
	logic dbus_request;
	logic dbus_rw;
	logic dbus_ready;
	logic [31:0] dbus_address;
	logic [31:0] dbus_rdata;
	logic [31:0] dbus_wdata;
	logic fault;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:255];
	logic [31:0] expected_address [$];
	logic [31:0] expected_data [$];
	logic [1:0] ibus_wait;
	logic [1:0] dbus_wait;
	integer seed;
	int cycle_count;
	int quiet_count;
	logic fault_seen;
	logic first_fetch_seen;
	logic quiet_phase;

	cpu UUT (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.o_ibus_request(ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_address(ibus_address),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_request(dbus_request),
		.o_dbus_rw(dbus_rw),
		.i_dbus_ready(dbus_ready),
		.o_dbus_address(dbus_address),
		.i_dbus_rdata(dbus_rdata),
		.o_dbus_wdata(dbus_wdata),
		.o_fault(fault)
	);

	always #5 clock = ~clock;

	//==================================================
	// Helpers

	function automatic logic [1:0] random_delay();
		int r;
		r = $random(seed);
		return r[1:0];
	endfunction

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic push_store(input logic [31:0] address, input logic [31:0] data);
		expected_address.push_back(address);
		expected_data.push_back(data);
	endtask

	// Register values of the program, step by step
	task automatic build_expected_stores();
		logic [31:0] x1;
		logic [31:0] x3;
		logic [31:0] x4;
		logic [31:0] x5;
		logic [31:0] x6;
		logic [31:0] x7;
		logic [31:0] x8;
		logic [31:0] x9;
		logic [31:0] x10;
		logic [31:0] x11;
		logic [31:0] x13;
		logic [31:0] x14;
		x1 = (32'h12345 << 12) + 32'h678;
		x3 = 32'd0 - 32'd3;
		x4 = x1 + x3;
		x5 = x4 - x1;
		x6 = x5 ^ x4;
		x7 = x6 & x1;
		x8 = x7 | x4;
		x9 = ($signed(x6) < $signed(x7)) ? 32'd1 : 32'd0;
		x10 = ($signed(x7) < 32'sd9) ? 32'd1 : 32'd0;
		x11 = x9 + x10;
		// Byte 40 is word 10 of the data memory
		x13 = 32'd10 * 32'd3 + x1;
		// Link of the jal at 0x50
		x14 = 32'h50 + 32'd4;
		push_store(cpu_pkg::STACK_POINTER, x8);
		push_store(cpu_pkg::STACK_POINTER - 32'd4, x11);
		push_store(32'h8, x6);
		push_store(32'hC, x13);
		push_store(32'h10, x14);
	endtask

	//==================================================
	// Stimulus and end of run

	initial begin
		arst_n <= 1'b0;
		ibus_ready <= 1'b0;
		ibus_rdata <= '0;
		dbus_ready <= 1'b0;
		dbus_rdata <= '0;
		seed = 32'h8c1b_3d7d;
		cycle_count = 0;
		quiet_count = 0;
		fault_seen = 1'b0;
		first_fetch_seen = 1'b0;
		quiet_phase = 1'b0;
		ibus_wait <= random_delay();
		dbus_wait <= random_delay();
		// Words past the program decode as opcode 0
		for (int k = 0; k < 64; k++)
			imem[k] = {25'(k), 7'b0000000};
		$readmemh("verification/program.hex", imem);
		for (int k = 0; k < 256; k++)
			dmem[k] <= 32'(k * 3);
		build_expected_stores();
		repeat (4) @(posedge clock);
		arst_n <= 1'b1;
		wait (quiet_count == QUIET_CYCLES);
		$display("SIMULATION PASSED");
		$finish;
	end

	//==================================================
	// Bus slaves, ready high for one cycle per transfer

	always @(posedge clock) begin
		if (arst_n) begin
			if (ibus_ready) begin
				ibus_ready <= 1'b0;
			end else if (ibus_request) begin
				if (ibus_wait == 2'd0) begin
					ibus_ready <= 1'b1;
					ibus_rdata <= imem[ibus_address[7:2]];
					ibus_wait <= random_delay();
				end else begin
					ibus_wait <= ibus_wait - 2'd1;
				end
			end
			if (dbus_ready) begin
				dbus_ready <= 1'b0;
				// Write lands on the completing edge
				if (dbus_rw)
					dmem[dbus_address[9:2]] <= dbus_wdata;
			end else if (dbus_request) begin
				if (dbus_wait == 2'd0) begin
					dbus_ready <= 1'b1;
					dbus_rdata <= dmem[dbus_address[9:2]];
					dbus_wait <= random_delay();
				end else begin
					dbus_wait <= dbus_wait - 2'd1;
				end
			end
		end
	end

	//==================================================
	// Checks

	always @(posedge clock) begin
		if (!arst_n) begin
			assert (!ibus_request && !dbus_request && !fault)
			else report_mismatch("bus request or fault active during reset");
		end else begin
			cycle_count = cycle_count + 1;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				$display("Timeout: %0d cycles without the final store and fault", cycle_count);
				abort_run();
			end
			// Request registered on the first edge after release
			if (ibus_request && !first_fetch_seen) begin
				first_fetch_seen = 1'b1;
				assert (ibus_address == cpu_pkg::RESET_VECTOR && cycle_count == 2)
				else report_mismatch($sformatf("first fetch in cycle %0d from %h",
					cycle_count, ibus_address));
			end
			if (quiet_phase) begin
				assert (!dbus_request)
				else report_mismatch("data bus request after the fault");
				quiet_count = quiet_count + 1;
			end
			if (dbus_request && dbus_ready && dbus_rw) begin
				assert (expected_address.size() > 0)
				else report_mismatch($sformatf("unexpected store of %h to %h",
					dbus_wdata, dbus_address));
				assert (dbus_address == expected_address[0] && dbus_wdata == expected_data[0])
				else report_mismatch($sformatf("store %h to %h, expected %h to %h",
					dbus_wdata, dbus_address, expected_data[0], expected_address[0]));
				void'(expected_address.pop_front());
				void'(expected_data.pop_front());
			end
			assert (fault || !fault_seen)
			else report_mismatch("o_fault dropped before reset");
			fault_seen = fault_seen | fault;
			if (fault_seen && expected_address.size() == 0)
				quiet_phase = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verification/program.hex */
// RV32I test program, one 32-bit instruction word in hex per line
// Line n holds the word at byte address 4*n, the comment gives address and assembly
123450B7 // 00 lui  x1, 0x12345
67808093 // 04 addi x1, x1, 0x678
FFD00193 // 08 addi x3, x0, -3
00308233 // 0C add  x4, x1, x3
401202B3 // 10 sub  x5, x4, x1
0042C333 // 14 xor  x6, x5, x4
001373B3 // 18 and  x7, x6, x1
0043E433 // 1C or   x8, x7, x4
007324B3 // 20 slt  x9, x6, x7
0093A513 // 24 slti x10, x7, 9
00A485B3 // 28 add  x11, x9, x10
00812023 // 2C sw   x8, 0(x2)
FEB12E23 // 30 sw   x11, -4(x2)
00602423 // 34 sw   x6, 8(x0)
02802603 // 38 lw   x12, 40(x0)
001606B3 // 3C add  x13, x12, x1
00D02623 // 40 sw   x13, 12(x0)
00A48463 // 44 beq  x9, x10, +8
00102023 // 48 sw   x1, 0(x0)    skipped
00519463 // 4C bne  x3, x5, +8   not taken
0080076F // 50 jal  x14, +8
00102223 // 54 sw   x1, 4(x0)    skipped
00E02823 // 58 sw   x14, 16(x0)
00000000 // 5C undefined opcode
00102A23 // 60 sw   x1, 20(x0)   never executed

/* sources.f */
common/cpu_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_registers.sv
src/cpu_forward.sv
src/cpu_execute.sv
src/cpu_memory.sv
src/cpu.sv
verification/tb_cpu.sv

/* Makefile */
# Verilator simulation of the RV32I core
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: sources.f $(SOURCES)
	verilator --binary --assert --top-module tb_cpu -Mdir obj_dir -f sources.f

run: obj_dir/Vtb_cpu verification/program.hex
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
